//--- cop_mcu_link.f
verilog/cop_bus_pkg.sv
verilog/cop_mcu_pkg.sv
verilog/cop_cen_gen.sv
verilog/cop_host_latch.sv
verilog/cop_mcu_port.sv
verilog/cop_mcu_link.sv
testbench/tb_cop_mcu_link.sv

//--- testbench/tb_cop_mcu_link.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CPU to MCU link that acts as both the main CPU and the
// 8751 and runs a table of mailbox, flag and interrupt steps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_cop_mcu_link;

    import cop_bus_pkg::*;
    import cop_mcu_pkg::*;

    localparam int MCU_DIV = 3;
    localparam int NSTEPS  = 18;

    // Step kinds
    localparam int KIND_HOST_WR = 0;
    localparam int KIND_RD_HI   = 1;
    localparam int KIND_RD_LO   = 2;
    localparam int KIND_WR_HI   = 3;
    localparam int KIND_WR_LO   = 4;
    localparam int KIND_FLAGS   = 5;
    localparam int KIND_ACK     = 6;

    // Port 2 values with active-low strobes
    localparam port_t P2_IDLE  = 8'hff;
    localparam port_t P2_RD_HI = 8'hef;
    localparam port_t P2_RD_LO = 8'hdf;
    localparam port_t P2_WR_LO = 8'hbf;
    localparam port_t P2_WR_HI = 8'h7f;
    localparam port_t P2_ACK   = 8'hf7;

    logic    clk24;
    logic    rst24;
    sel_t    sel;
    logic    rnw;
    dsn_t    dsn;
    word_t   cpu_dout;
    word_t   mcu_dout;
    port_t   p0o;
    port_t   p1o;
    port_t   p2o;
    port_t   p3o;
    port_t   p0i;
    port_t   p3i;
    logic    int1n;
    logic    cen_mcu;
    flag2_t  snd_flag;
    flag2_t  b1_flag;
    flag2_t  mix_flag;
    logic    b0_flag;
    crbank_t cr_bank;

    // Step table
    int      kind_tab [NSTEPS];
    word_t   data_tab [NSTEPS];
    dsn_t    dsn_tab  [NSTEPS];
    word_t   exp_tab  [NSTEPS];
    int      rows;

    // Reference model state
    logic [31:0] lfsr;
    word_t       mbox_m;
    word_t       dout_m;
    logic        pending_m;
    logic        sel0_m;
    sel_hi_t     sel_hi_prev;

    cop_mcu_link #(
        .MCU_DIV ( MCU_DIV )
    ) u_dut (
        .clk24    ( clk24    ),
        .rst24    ( rst24    ),
        .sel      ( sel      ),
        .rnw      ( rnw      ),
        .dsn      ( dsn      ),
        .cpu_dout ( cpu_dout ),
        .mcu_dout ( mcu_dout ),
        .p0o      ( p0o      ),
        .p1o      ( p1o      ),
        .p2o      ( p2o      ),
        .p3o      ( p3o      ),
        .p0i      ( p0i      ),
        .p3i      ( p3i      ),
        .int1n    ( int1n    ),
        .cen_mcu  ( cen_mcu  ),
        .snd_flag ( snd_flag ),
        .b1_flag  ( b1_flag  ),
        .mix_flag ( mix_flag ),
        .b0_flag  ( b0_flag  ),
        .cr_bank  ( cr_bank  )
    );

    always #4 clk24 = ~clk24;

    // Galois LFSR stepped once per bit drawn
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int b = 0; b < 16; b++) begin
            w = {w[14:0], lfsr_bit()};
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Draw the data for one row and advance the model
    task automatic add_row(input int kind, input dsn_t lanes);
        word_t d;
        word_t e;
        d = rand_word();
        e = '0;
        case (kind)
            KIND_HOST_WR: begin
                if (!lanes[1]) begin
                    mbox_m[15:8] = d[15:8];
                end
                if (!lanes[0]) begin
                    mbox_m[7:0] = d[7:0];
                end
                if (!sel0_m) begin
                    pending_m = 1'b1;
                end
                sel0_m = 1'b1;
                e = {15'd0, ~pending_m};
            end
            KIND_RD_HI: e = {8'h00, mbox_m[15:8]};
            KIND_RD_LO: e = {8'h00, mbox_m[7:0]};
            KIND_WR_HI: begin
                dout_m[15:8] = d[7:0];
                e = dout_m;
            end
            KIND_WR_LO: begin
                dout_m[7:0] = d[7:0];
                e = dout_m;
            end
            // snd, b1, b0 and mix from p1o 6..0 followed by cr_bank from p3o 2..0
            KIND_FLAGS: e = {6'd0, d[6:0], d[10:8]};
            KIND_ACK: begin
                pending_m = 1'b0;
                sel0_m    = 1'b0;
                e = 16'h0001;
            end
            default: e = '0;
        endcase
        kind_tab[rows] = kind;
        data_tab[rows] = d;
        dsn_tab[rows]  = lanes;
        exp_tab[rows]  = e;
        rows++;
    endtask

    task automatic build_table();
        rows = 0;
        add_row(KIND_HOST_WR, 2'b00);
        add_row(KIND_RD_HI, 2'b11);
        add_row(KIND_RD_LO, 2'b11);
        // Single lane writes while select 0 stays high
        add_row(KIND_HOST_WR, 2'b10);
        add_row(KIND_RD_HI, 2'b11);
        add_row(KIND_RD_LO, 2'b11);
        add_row(KIND_HOST_WR, 2'b01);
        add_row(KIND_RD_HI, 2'b11);
        add_row(KIND_RD_LO, 2'b11);
        add_row(KIND_ACK, 2'b11);
        add_row(KIND_WR_LO, 2'b11);
        add_row(KIND_WR_HI, 2'b11);
        add_row(KIND_WR_LO, 2'b11);
        add_row(KIND_FLAGS, 2'b11);
        add_row(KIND_FLAGS, 2'b11);
        add_row(KIND_HOST_WR, 2'b01);
        add_row(KIND_RD_HI, 2'b11);
        add_row(KIND_ACK, 2'b11);
    endtask

    task automatic wait_for_cen();
        @(negedge clk24);
        while (!cen_mcu) begin
            @(negedge clk24);
        end
    endtask

    // Hold a port 2 strobe over one MCU enable and release it afterwards
    task automatic mcu_cycle(input port_t strobe, input port_t p0_val);
        @(posedge clk24);
        p2o <= strobe;
        p0o <= p0_val;
        wait_for_cen();
        @(posedge clk24);
        p2o <= P2_IDLE;
        @(negedge clk24);
    endtask

    task automatic host_write(input int i);
        logic  rise;
        string name;
        name = $sformatf("step %0d host write", i);
        @(posedge clk24);
        rise     = !sel[0];
        sel[0]   <= 1'b1;
        rnw      <= 1'b0;
        dsn      <= dsn_tab[i];
        cpu_dout <= data_tab[i];
        @(posedge clk24);
        rnw <= 1'b1;
        dsn <= 2'b11;
        @(negedge clk24);
        if (rise) begin
            check_value({name, " int1n one cycle after edge"}, 1, int1n);
        end
        @(posedge clk24);
        @(negedge clk24);
        check_value({name, " int1n"}, exp_tab[i], int1n);
    endtask

    task automatic flag_load(input int i);
        word_t d;
        string name;
        d    = data_tab[i];
        name = $sformatf("step %0d flag load", i);
        @(posedge clk24);
        p1o      <= d[7:0];
        // Port 3 bits 7..5 kept apart from the select lines
        p3o      <= {~d[15:13], d[12:8]};
        sel[5:3] <= d[15:13];
        // Select lines reach p3i one cycle behind port 3
        @(negedge clk24);
        check_value({name, " p3i old select"}, {sel_hi_prev, d[12:8]}, p3i);
        wait_for_cen();
        @(posedge clk24);
        @(negedge clk24);
        check_value({name, " flags"}, exp_tab[i],
                    {snd_flag, b1_flag, b0_flag, mix_flag, cr_bank});
        check_value({name, " p3i"}, {d[15:13], d[12:8]}, p3i);
        sel_hi_prev = d[15:13];
    endtask

    task automatic check_reset_state();
        @(negedge clk24);
        check_value("reset int1n", 1, int1n);
        check_value("reset mcu_dout", 0, mcu_dout);
        check_value("reset p0i", 0, p0i);
        check_value("reset flags", 0, {snd_flag, b1_flag, b0_flag, mix_flag, cr_bank});
        check_value("reset cen_mcu", 0, cen_mcu);
        // First enable MCU_DIV edges after release and one every MCU_DIV after that
        for (int k = 1; k <= 3 * MCU_DIV; k++) begin
            @(negedge clk24);
            check_value($sformatf("cen_mcu cycle %0d", k), (k % MCU_DIV) == 0, cen_mcu);
        end
    endtask

    initial begin
        clk24       = 1'b0;
        rst24       = 1'b1;
        sel         = '0;
        rnw         = 1'b1;
        dsn         = 2'b11;
        cpu_dout    = '0;
        p0o         = '0;
        p1o         = '0;
        p2o         = P2_IDLE;
        p3o         = '0;
        lfsr        = 32'h585e;
        mbox_m      = '0;
        dout_m      = '0;
        pending_m   = 1'b0;
        sel0_m      = 1'b0;
        sel_hi_prev = '0;
        build_table();
        repeat (4) @(posedge clk24);
        rst24 <= 1'b0;
        check_reset_state();
        for (int i = 0; i < rows; i++) begin
            case (kind_tab[i])
                KIND_HOST_WR: host_write(i);
                KIND_RD_HI: begin
                    mcu_cycle(P2_RD_HI, p0o);
                    check_value($sformatf("step %0d read upper", i), exp_tab[i], p0i);
                end
                KIND_RD_LO: begin
                    mcu_cycle(P2_RD_LO, p0o);
                    check_value($sformatf("step %0d read lower", i), exp_tab[i], p0i);
                end
                KIND_WR_HI: begin
                    mcu_cycle(P2_WR_HI, data_tab[i][7:0]);
                    check_value($sformatf("step %0d write upper", i), exp_tab[i], mcu_dout);
                end
                KIND_WR_LO: begin
                    mcu_cycle(P2_WR_LO, data_tab[i][7:0]);
                    check_value($sformatf("step %0d write lower", i), exp_tab[i], mcu_dout);
                end
                KIND_FLAGS: flag_load(i);
                KIND_ACK: begin
                    mcu_cycle(P2_ACK, p0o);
                    check_value($sformatf("step %0d acknowledge", i), exp_tab[i], int1n);
                    // Drop select 0 so the next host write makes a new edge
                    @(posedge clk24);
                    sel[0] <= 1'b0;
                end
                default: check_value($sformatf("step %0d kind", i), 0, kind_tab[i]);
            endcase
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NSTEPS * 40) @(posedge clk24);
        $display("Timeout: the step table did not finish in %0d cycles", NSTEPS * 40);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- verilog/cop_mcu_link.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU to protection MCU link at 24 MHz: enable divider, host mailbox
// stage and MCU port stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cop_mcu_link #(
    parameter int MCU_DIV = 3
) (
    input  logic                 clk24,
    input  logic                 rst24,
    // Main CPU side
    input  cop_bus_pkg::sel_t    sel,
    input  logic                 rnw,
    input  cop_bus_pkg::dsn_t    dsn,
    input  cop_bus_pkg::word_t   cpu_dout,
    output cop_bus_pkg::word_t   mcu_dout,
    // MCU ports
    input  cop_mcu_pkg::port_t   p0o,
    input  cop_mcu_pkg::port_t   p1o,
    input  cop_mcu_pkg::port_t   p2o,
    input  cop_mcu_pkg::port_t   p3o,
    output cop_mcu_pkg::port_t   p0i,
    output cop_mcu_pkg::port_t   p3i,
    output logic                 int1n,
    output logic                 cen_mcu,
    // ROM bank flags
    output cop_mcu_pkg::flag2_t  snd_flag,
    output cop_mcu_pkg::flag2_t  b1_flag,
    output cop_mcu_pkg::flag2_t  mix_flag,
    output logic                 b0_flag,
    output cop_mcu_pkg::crbank_t cr_bank
);

    import cop_bus_pkg::*;
    import cop_mcu_pkg::*;

    word_t   mcu_din;
    logic    req;
    sel_hi_t sel_hi;

    cop_cen_gen #(
        .MCU_DIV ( MCU_DIV )
    ) u_cen (
        .clk24   ( clk24   ),
        .rst24   ( rst24   ),
        .cen_mcu ( cen_mcu )
    );

    cop_host_latch u_host (
        .clk24    ( clk24    ),
        .rst24    ( rst24    ),
        .sel      ( sel      ),
        .rnw      ( rnw      ),
        .dsn      ( dsn      ),
        .cpu_dout ( cpu_dout ),
        .mcu_din  ( mcu_din  ),
        .req      ( req      ),
        .sel_hi   ( sel_hi   )
    );

    cop_mcu_port u_port (
        .clk24    ( clk24    ),
        .rst24    ( rst24    ),
        .cen_mcu  ( cen_mcu  ),
        .p0o      ( p0o      ),
        .p1o      ( p1o      ),
        .p2o      ( p2o      ),
        .p3o      ( p3o      ),
        .mcu_din  ( mcu_din  ),
        .req      ( req      ),
        .sel_hi   ( sel_hi   ),
        .p0i      ( p0i      ),
        .p3i      ( p3i      ),
        .int1n    ( int1n    ),
        .mcu_dout ( mcu_dout ),
        .snd_flag ( snd_flag ),
        .b1_flag  ( b1_flag  ),
        .mix_flag ( mix_flag ),
        .b0_flag  ( b0_flag  ),
        .cr_bank  ( cr_bank  )
    );

endmodule

`default_nettype wire

//--- verilog/cop_mcu_port.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU port stage: port 2 strobe decode into mailbox byte reads/writes,
// INT1 request handling and the ROM bank flags driven on ports 1 and 3
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cop_mcu_port (
    input  logic                 clk24,
    input  logic                 rst24,
    input  logic                 cen_mcu,
    input  cop_mcu_pkg::port_t   p0o,
    input  cop_mcu_pkg::port_t   p1o,
    input  cop_mcu_pkg::port_t   p2o,
    input  cop_mcu_pkg::port_t   p3o,
    input  cop_bus_pkg::word_t   mcu_din,
    input  logic                 req,
    input  cop_mcu_pkg::sel_hi_t sel_hi,
    output cop_mcu_pkg::port_t   p0i,
    output cop_mcu_pkg::port_t   p3i,
    output logic                 int1n,
    output cop_bus_pkg::word_t   mcu_dout,
    output cop_mcu_pkg::flag2_t  snd_flag,
    output cop_mcu_pkg::flag2_t  b1_flag,
    output cop_mcu_pkg::flag2_t  mix_flag,
    output logic                 b0_flag,
    output cop_mcu_pkg::crbank_t cr_bank
);

    import cop_mcu_pkg::*;

    irq_state_t irq_state;

    logic rd_hi;
    logic rd_lo;
    logic wr_lo;
    logic wr_hi;
    logic irq_ack;

    // Port 2 strobes are all active low
    assign rd_hi   = ~p2o[4];
    assign rd_lo   = ~p2o[5];
    assign wr_lo   = ~p2o[6];
    assign wr_hi   = ~p2o[7];
    assign irq_ack = ~p2o[3];

    // MCU reads back select lines 5..3 on the top of port 3
    assign p3i = {sel_hi, p3o[4:0]};

    assign int1n = (irq_state != IRQ_PENDING);

    // Request is taken on any edge, acknowledge only when the MCU runs
    always_ff @(posedge clk24, posedge rst24) begin
        if (rst24) begin
            irq_state <= IRQ_IDLE;
        end else begin
            case (irq_state)
                IRQ_IDLE: begin
                    if (req && !(cen_mcu && irq_ack)) begin
                        irq_state <= IRQ_PENDING;
                    end
                end
                IRQ_PENDING: begin
                    if (cen_mcu && irq_ack) begin
                        irq_state <= IRQ_IDLE;
                    end
                end
                default: irq_state <= IRQ_IDLE;
            endcase
        end
    end

    // Mailbox byte transfers, one per MCU enable
    always_ff @(posedge clk24, posedge rst24) begin
        if (rst24) begin
            p0i      <= '0;
            mcu_dout <= '0;
        end else if (cen_mcu) begin
            if (rd_hi) begin
                p0i <= mcu_din[15:8];
            end
            // lower lane takes over if firmware pulls both
            if (rd_lo) begin
                p0i <= mcu_din[7:0];
            end
            if (wr_hi) begin
                mcu_dout[15:8] <= p0o;
            end
            if (wr_lo) begin
                mcu_dout[7:0] <= p0o;
            end
        end
    end

    // ROM bank flags
    always_ff @(posedge clk24, posedge rst24) begin
        if (rst24) begin
            snd_flag <= '0;
            b1_flag  <= '0;
            b0_flag  <= 1'b0;
            mix_flag <= '0;
            cr_bank  <= '0;
        end else if (cen_mcu) begin
            {snd_flag, b1_flag, b0_flag, mix_flag} <= p1o[6:0];
            cr_bank <= p3o[2:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/cop_host_latch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host side of the MCU mailbox: catches CPU word writes by byte lane,
// turns the select 0 rising edge into a request pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cop_host_latch (
    input  logic                 clk24,
    input  logic                 rst24,
    input  cop_bus_pkg::sel_t    sel,
    input  logic                 rnw,
    input  cop_bus_pkg::dsn_t    dsn,
    input  cop_bus_pkg::word_t   cpu_dout,
    output cop_bus_pkg::word_t   mcu_din,
    output logic                 req,
    output cop_mcu_pkg::sel_hi_t sel_hi
);

    import cop_bus_pkg::*;

    logic  sel0_last;
    logic  host_wr;
    word_t wr_mask;

    // Mailbox write cycle from the main CPU
    assign host_wr = sel[0] & ~rnw;

    // Expand the active-low strobes into a per-bit lane mask
    assign wr_mask = {{8{~dsn[1]}}, {8{~dsn[0]}}};

    // Mailbox word, later writes simply overwrite it
    always_ff @(posedge clk24, posedge rst24) begin
        if (rst24) begin
            mcu_din <= '0;
        end else if (host_wr) begin
            mcu_din <= (cpu_dout & wr_mask) | (mcu_din & ~wr_mask);
        end
    end

    // Edge detect on select 0 and read-back copy of the upper lines
    always_ff @(posedge clk24, posedge rst24) begin
        if (rst24) begin
            sel0_last <= 1'b0;
            req       <= 1'b0;
            sel_hi    <= '0;
        end else begin
            sel0_last <= sel[0];
            req       <= sel[0] & ~sel0_last;
            sel_hi    <= sel[5:3];
        end
    end

endmodule

`default_nettype wire

//--- verilog/cop_cen_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU clock enable, one clk24 pulse every MCU_DIV cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cop_cen_gen #(
    parameter int MCU_DIV = 3
) (
    input  logic clk24,
    input  logic rst24,
    output logic cen_mcu
);

    // Counter needs at least one bit even for a divide by one
    localparam int CNT_W = (MCU_DIV > 1) ? $clog2(MCU_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MCU_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Pulse is registered on the wrap, so the first one lands
    // MCU_DIV edges after reset goes away
    always_ff @(posedge clk24, posedge rst24) begin
        if (rst24) begin
            cnt     <= '0;
            cen_mcu <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt     <= '0;
                cen_mcu <= 1'b1;
            end else begin
                cnt     <= cnt + 1'b1;
                cen_mcu <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cop_mcu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU side types of the link: 8751 port width, ROM bank flag fields
// and the states of the MCU interrupt line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cop_mcu_pkg;

    // Each 8751 port is one byte wide
    localparam int PORT_W = 8;

    // Select lines 5 to 3 as seen on port 3
    localparam int SEL_HI_W = 3;

    // Paired bank flags on port 1
    localparam int FLAG2_W = 2;

    // Character ROM bank on port 3 bits 2 to 0
    localparam int CRBANK_W = 3;

    typedef logic [PORT_W-1:0] port_t;

    typedef logic [SEL_HI_W-1:0] sel_hi_t;

    typedef logic [FLAG2_W-1:0] flag2_t;

    typedef logic [CRBANK_W-1:0] crbank_t;

    // INT1 line towards the MCU, low while pending
    typedef enum logic {
        IRQ_IDLE    = 1'b0,
        IRQ_PENDING = 1'b1
    } irq_state_t;

endpackage

`default_nettype wire

//--- verilog/cop_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main CPU side types of the CPU to MCU link: data word, byte strobes
// and the select lines decoded by the CPU address map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cop_bus_pkg;

    // 68000 data bus width
    localparam int WORD_W = 16;

    // One active-low strobe per byte lane
    localparam int DSN_W = 2;

    // MCU select lines from the main CPU decoder
    localparam int SEL_W = 6;

    // CPU data word, upper byte in bits 15 to 8
    typedef logic [WORD_W-1:0] word_t;

    // Byte strobes, bit 1 upper byte, bit 0 lower byte
    typedef logic [DSN_W-1:0] dsn_t;

    // Bit 0 is the mailbox select, bits 5 to 3 are read back by the MCU
    typedef logic [SEL_W-1:0] sel_t;

endpackage

`default_nettype wire
